// ==== files.f ====
+incdir+include
source/adc_par_pkg.sv
source/adc_step_timer.sv
source/adc_sample_capture.sv
source/adc_conv_fsm.sv
source/adc_par_ctrl.sv
test/adc_par_model.sv
test/adc_par_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: adc_par_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - source/adc_par_pkg.sv
      - source/adc_step_timer.sv
      - source/adc_sample_capture.sv
      - source/adc_conv_fsm.sv
      - source/adc_par_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/adc_par_model.sv
      - test/adc_par_ctrl_tb.sv

// ==== include/adc_timing.svh ====
// ADC model timing defaults
`ifndef ADC_TIMING_SVH
`define ADC_TIMING_SVH

// number of sys_clk_i cycles the converter model keeps busy high
// after it has seen a convert start pulse
`define ADC_DEFAULT_BUSY_CYCLES 40

`endif

// ==== test/adc_par_ctrl_tb.sv ====
// AD7616 parallel controller testbench
`timescale 1ns/1ps
`include "adc_timing.svh"

module adc_par_ctrl_tb;

    import adc_par_pkg::*;

    localparam int NUM_ROWS   = 6;
    localparam int ACK_LIMIT  = 400;
    localparam int BUSY_LIMIT = 400;

    logic        sys_clk;
    logic        rst_n;
    logic        conv_req;
    logic        conv_ack;
    logic        busy_timeout;
    adc_word_t   sample_a;
    adc_word_t   sample_b;
    logic        rx_busy;
    adc_word_t   rx_db;
    logic        rx_cnvst;
    logic        rx_cs_n;
    logic        rx_rd_n;
    logic [15:0] model_busy_len;
    adc_word_t   model_word_a;
    adc_word_t   model_word_b;

    // stimulus table where a busy length of zero means the model default
    adc_word_t   row_word_a [NUM_ROWS];
    adc_word_t   row_word_b [NUM_ROWS];
    int unsigned row_busy [NUM_ROWS];
    logic        row_timeout [NUM_ROWS];
    int unsigned row_hold [NUM_ROWS];

    integer    seed;
    adc_word_t exp_a;
    adc_word_t exp_b;
    int        error_cnt    = 0;
    int        tests_run    = 0;
    int        tests_failed = 0;
    bit        hung         = 1'b0;
    int        rd_falls     = 0;
    int        cnvst_width  = 0;
    int        cnvst_pulses = 0;
    logic      rd_n_prev    = 1'b1;

    adc_par_ctrl u_dut (
        .sys_clk_i      (sys_clk),
        .rst_n_i        (rst_n),
        .conv_req_i     (conv_req),
        .conv_ack_o     (conv_ack),
        .busy_timeout_o (busy_timeout),
        .sample_a_o     (sample_a),
        .sample_b_o     (sample_b),
        .rx_busy_i      (rx_busy),
        .rx_db_i        (rx_db),
        .rx_cnvst_o     (rx_cnvst),
        .rx_cs_n_o      (rx_cs_n),
        .rx_rd_n_o      (rx_rd_n)
    );

    adc_par_model u_model (
        .sys_clk_i     (sys_clk),
        .rst_n_i       (rst_n),
        .rx_cnvst_i    (rx_cnvst),
        .rx_cs_n_i     (rx_cs_n),
        .rx_rd_n_i     (rx_rd_n),
        .rx_busy_o     (rx_busy),
        .rx_db_o       (rx_db),
        .busy_cycles_i (model_busy_len),
        .word_a_i      (model_word_a),
        .word_b_i      (model_word_b)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // ************************************************************
    // strobe monitors sampled on the falling edge
    // ************************************************************

    // counts read strobes, checks chip select and every convert pulse width
    always @(negedge sys_clk) begin
        if (!rst_n) begin
            rd_n_prev   = 1'b1;
            cnvst_width = 0;
        end else begin
            if (rd_n_prev && !rx_rd_n) begin
                rd_falls++;
            end
            rd_n_prev = rx_rd_n;
            // chip select frames both reads and the gap between them
            if (!rx_rd_n || (rd_falls > 0 && rd_falls < NUM_READS)) begin
                compare_value("rx_cs_n_o", rx_cs_n, 1'b0);
            end else begin
                compare_value("rx_cs_n_o", rx_cs_n, 1'b1);
            end
            if (rx_cnvst) begin
                cnvst_width++;
            end else if (cnvst_width != 0) begin
                compare_value("rx_cnvst_o width", cnvst_width, CNVST_CYCLES);
                cnvst_pulses++;
                cnvst_width = 0;
            end
        end
    end

    // ************************************************************
    // helpers
    // ************************************************************

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            error_cnt++;
        end
    endtask

    // the timeout row and the last row keep ack high for 30 cycles as a slow host
    task automatic load_table();
        seed = 32'h400f_0255;
        row_word_a[0] = 16'h1234;
        row_word_b[0] = 16'habcd;
        row_word_a[1] = adc_word_t'($random(seed));
        row_word_b[1] = adc_word_t'($random(seed));
        row_word_a[2] = 16'h0000;
        row_word_b[2] = 16'hffff;
        row_word_a[3] = adc_word_t'($random(seed));
        row_word_b[3] = adc_word_t'($random(seed));
        row_word_a[4] = adc_word_t'($random(seed));
        row_word_b[4] = adc_word_t'($random(seed));
        row_word_a[5] = 16'h8001;
        row_word_b[5] = 16'h7ffe;
        row_busy    = '{10, 0, 150, 250, 10, 40};
        row_timeout = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        row_hold    = '{0, 0, 0, 30, 0, 30};
    endtask

    // waited counts the falling edges up to and including the matching one
    task automatic wait_for_ack(input logic level, output int waited, output bit ok);
        ok     = 1'b0;
        waited = 0;
        while (!ok && waited < ACK_LIMIT) begin
            @(negedge sys_clk);
            waited++;
            if (conv_ack === level) begin
                ok = 1'b1;
            end
        end
    endtask

    // a timed out conversion can leave the model busy past the ack
    task automatic drain_busy(output bit ok);
        int n;

        n  = 0;
        ok = 1'b0;
        while (!ok && n < BUSY_LIMIT) begin
            @(negedge sys_clk);
            n++;
            if (rx_busy === 1'b0) begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (hung || error_cnt != err_before) begin
            tests_failed++;
            $display("test %s FAILED", name);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    task automatic run_row(input int row);
        int          waited;
        bit          ok;
        int          err_before;
        int          pulses_before;
        int unsigned busy_len;
        string       name;

        err_before = error_cnt;
        busy_len   = (row_busy[row] == 0) ? `ADC_DEFAULT_BUSY_CYCLES : row_busy[row];
        name       = $sformatf("row %0d busy %0d", row, busy_len);
        drain_busy(ok);
        if (!ok) begin
            $display("model busy stayed high for %0d cycles before %s", BUSY_LIMIT, name);
            hung = 1'b1;
            end_test(name, err_before);
            return;
        end
        @(posedge sys_clk);
        model_busy_len <= 16'(row_busy[row]);
        model_word_a   <= row_word_a[row];
        model_word_b   <= row_word_b[row];
        conv_req       <= 1'b1;
        rd_falls      = 0;
        pulses_before = cnvst_pulses;
        wait_for_ack(1'b1, waited, ok);
        if (!ok) begin
            $display("no ack from the DUT within %0d cycles in %s", ACK_LIMIT, name);
            hung = 1'b1;
            end_test(name, err_before);
            return;
        end
        // a timeout leaves the samples of the previous conversion in place
        if (!row_timeout[row]) begin
            exp_a = row_word_a[row];
            exp_b = row_word_b[row];
        end
        compare_value("busy_timeout_o", busy_timeout, row_timeout[row]);
        compare_value("sample_a_o", sample_a, exp_a);
        compare_value("sample_b_o", sample_b, exp_b);
        compare_value("rx_rd_n_o falls", rd_falls, row_timeout[row] ? 0 : NUM_READS);
        compare_value("rx_cnvst_o pulses", cnvst_pulses - pulses_before, 1);
        // a slow host holds req so ack must stay high and no new conversion may start
        if (row_hold[row] != 0) begin
            repeat (row_hold[row]) begin
                @(negedge sys_clk);
                compare_value("conv_ack_o", conv_ack, 1'b1);
            end
            compare_value("rx_cnvst_o pulses", cnvst_pulses - pulses_before, 1);
        end
        @(posedge sys_clk);
        conv_req <= 1'b0;
        wait_for_ack(1'b0, waited, ok);
        if (!ok) begin
            $display("ack did not fall within %0d cycles in %s", ACK_LIMIT, name);
            hung = 1'b1;
        end else begin
            // one cycle after req falls is seen on the second falling edge
            compare_value("conv_ack_o fall cycles", waited, 2);
        end
        end_test(name, err_before);
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************

    initial begin
        int err_before;

        rst_n          <= 1'b0;
        conv_req       <= 1'b0;
        model_busy_len <= '0;
        model_word_a   <= '0;
        model_word_b   <= '0;
        exp_a = '0;
        exp_b = '0;
        load_table();
        repeat (16) @(posedge sys_clk);
        rst_n <= 1'b1;

        @(negedge sys_clk);
        err_before = error_cnt;
        compare_value("conv_ack_o", conv_ack, 1'b0);
        compare_value("rx_cnvst_o", rx_cnvst, 1'b0);
        compare_value("rx_cs_n_o", rx_cs_n, 1'b1);
        compare_value("rx_rd_n_o", rx_rd_n, 1'b1);
        compare_value("busy_timeout_o", busy_timeout, 1'b0);
        compare_value("sample_a_o", sample_a, 0);
        compare_value("sample_b_o", sample_b, 0);
        end_test("reset", err_before);

        for (int row = 0; row < NUM_ROWS && !hung; row++) begin
            run_row(row);
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, error_cnt);
        if (tests_failed == 0 && error_cnt == 0 && !hung) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== test/adc_par_model.sv ====
// AD7616 parallel converter model
`timescale 1ns/1ps
`include "adc_timing.svh"

module adc_par_model (
    input  logic                   sys_clk_i,
    input  logic                   rst_n_i,
    // strobes from the controller
    input  logic                   rx_cnvst_i,
    input  logic                   rx_cs_n_i,
    input  logic                   rx_rd_n_i,
    // converter outputs
    output logic                   rx_busy_o,
    output adc_par_pkg::adc_word_t rx_db_o,
    // per conversion settings, a busy length of zero selects the default
    input  logic [15:0]            busy_cycles_i,
    input  adc_par_pkg::adc_word_t word_a_i,
    input  adc_par_pkg::adc_word_t word_b_i
);

    import adc_par_pkg::*;

    logic        cnvst_q;
    logic        rd_n_q;
    logic [15:0] busy_left_q;
    logic [1:0]  rd_cnt_q;
    logic [15:0] busy_len;

    assign busy_len = (busy_cycles_i == '0) ? 16'(`ADC_DEFAULT_BUSY_CYCLES) : busy_cycles_i;

    // ************************************************************
    // busy and data bus
    // ************************************************************

    // busy goes high on the edge after convert start is first seen high
    // and stays high for busy_len cycles
    // the first read after a conversion returns channel A, the second channel B
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            cnvst_q     <= 1'b0;
            rd_n_q      <= 1'b1;
            busy_left_q <= '0;
            rd_cnt_q    <= '0;
            rx_busy_o   <= 1'b0;
            rx_db_o     <= '0;
        end else begin
            cnvst_q <= rx_cnvst_i;
            rd_n_q  <= rx_rd_n_i;
            // a new convert edge restarts the busy time even over an old one
            if (rx_cnvst_i && !cnvst_q) begin
                rx_busy_o   <= 1'b1;
                busy_left_q <= busy_len - 1'b1;
                rd_cnt_q    <= '0;
            end else if (rx_busy_o) begin
                if (busy_left_q == '0) begin
                    rx_busy_o <= 1'b0;
                end else begin
                    busy_left_q <= busy_left_q - 1'b1;
                end
            end
            // the word appears one cycle into the read low phase
            if (!rx_rd_n_i && rd_n_q && !rx_cs_n_i) begin
                rx_db_o  <= (rd_cnt_q == '0) ? word_a_i : word_b_i;
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
        end
    end

endmodule

// ==== source/adc_par_ctrl.sv ====
// AD7616 parallel conversion controller
`timescale 1ns/1ps

module adc_par_ctrl (
    input  logic                   sys_clk_i,
    input  logic                   rst_n_i,
    // host handshake
    input  logic                   conv_req_i,
    output logic                   conv_ack_o,
    output logic                   busy_timeout_o,
    output adc_par_pkg::adc_word_t sample_a_o,
    output adc_par_pkg::adc_word_t sample_b_o,
    // converter parallel interface
    input  logic                   rx_busy_i,
    input  adc_par_pkg::adc_word_t rx_db_i,
    output logic                   rx_cnvst_o,
    output logic                   rx_cs_n_o,
    output logic                   rx_rd_n_o
);

    import adc_par_pkg::*;

    // FSM to timer
    logic     tmr_load;
    tmr_cnt_t tmr_load_val;
    logic     tmr_done;

    // FSM to capture
    logic cap_start;
    logic cap_strobe;
    logic cap_last;

    // sequences the handshake and every converter strobe
    adc_conv_fsm u_fsm (
        .sys_clk_i      (sys_clk_i),
        .rst_n_i        (rst_n_i),
        .conv_req_i     (conv_req_i),
        .conv_ack_o     (conv_ack_o),
        .busy_timeout_o (busy_timeout_o),
        .rx_busy_i      (rx_busy_i),
        .rx_cnvst_o     (rx_cnvst_o),
        .rx_cs_n_o      (rx_cs_n_o),
        .rx_rd_n_o      (rx_rd_n_o),
        .tmr_load_o     (tmr_load),
        .tmr_load_val_o (tmr_load_val),
        .tmr_done_i     (tmr_done),
        .cap_start_o    (cap_start),
        .cap_strobe_o   (cap_strobe),
        .cap_last_i     (cap_last)
    );

    // shared by every timed phase, only one phase runs at a time
    adc_step_timer u_timer (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .load_i     (tmr_load),
        .load_val_i (tmr_load_val),
        .done_o     (tmr_done)
    );

    // holds the channel samples seen by the host
    adc_sample_capture u_capture (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .start_i    (cap_start),
        .strobe_i   (cap_strobe),
        .db_i       (rx_db_i),
        .sample_a_o (sample_a_o),
        .sample_b_o (sample_b_o),
        .last_o     (cap_last)
    );

endmodule

// ==== source/adc_conv_fsm.sv ====
// AD7616 parallel conversion FSM
`timescale 1ns/1ps

module adc_conv_fsm (
    input  logic                  sys_clk_i,
    input  logic                  rst_n_i,
    // host handshake
    input  logic                  conv_req_i,
    output logic                  conv_ack_o,
    output logic                  busy_timeout_o,
    // converter control
    input  logic                  rx_busy_i,
    output logic                  rx_cnvst_o,
    output logic                  rx_cs_n_o,
    output logic                  rx_rd_n_o,
    // phase timer
    output logic                  tmr_load_o,
    output adc_par_pkg::tmr_cnt_t tmr_load_val_o,
    input  logic                  tmr_done_i,
    // sample capture
    output logic                  cap_start_o,
    output logic                  cap_strobe_o,
    input  logic                  cap_last_i
);

    import adc_par_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        timeout_q;

    // ************************************************************
    // next state and phase timer loads
    // ************************************************************

    // the timer is loaded with the phase length minus one on the edge
    // that enters the phase, done then rises in the last cycle of the phase
    always_comb begin
        state_d        = state_q;
        tmr_load_o     = 1'b0;
        tmr_load_val_o = '0;
        cap_start_o    = 1'b0;
        cap_strobe_o   = 1'b0;

        case (state_q)
            ST_IDLE: begin
                // a new request starts the convert pulse and rewinds the capture
                if (conv_req_i) begin
                    state_d        = ST_CNVST;
                    tmr_load_o     = 1'b1;
                    tmr_load_val_o = tmr_cnt_t'(CNVST_CYCLES - 1);
                    cap_start_o    = 1'b1;
                end
            end
            ST_CNVST: begin
                if (tmr_done_i) begin
                    state_d        = ST_BUSY_WAIT;
                    tmr_load_o     = 1'b1;
                    tmr_load_val_o = tmr_cnt_t'(BUSY_TIMEOUT_CYCLES - 1);
                end
            end
            ST_BUSY_WAIT: begin
                // busy falling has priority over a timeout in the same cycle
                if (!rx_busy_i) begin
                    state_d        = ST_RD_LOW;
                    tmr_load_o     = 1'b1;
                    tmr_load_val_o = tmr_cnt_t'(RD_LOW_CYCLES - 1);
                end else if (tmr_done_i) begin
                    state_d = ST_ACK;
                end
            end
            ST_RD_LOW: begin
                // the data bus is sampled on the edge that raises rd_n
                if (tmr_done_i) begin
                    state_d        = ST_RD_HIGH;
                    tmr_load_o     = 1'b1;
                    tmr_load_val_o = tmr_cnt_t'(RD_HIGH_CYCLES - 1);
                    cap_strobe_o   = 1'b1;
                end
            end
            ST_RD_HIGH: begin
                // cap_last_i is already updated on the first cycle here
                // so the final read goes to ack without the full gap
                if (cap_last_i) begin
                    state_d = ST_ACK;
                end else if (tmr_done_i) begin
                    state_d        = ST_RD_LOW;
                    tmr_load_o     = 1'b1;
                    tmr_load_val_o = tmr_cnt_t'(RD_LOW_CYCLES - 1);
                end
            end
            ST_ACK: begin
                // a slow host simply parks the FSM here
                if (!conv_req_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ************************************************************
    // state and timeout flag
    // ************************************************************

    // the flag only changes when ack is about to rise so it holds
    // its value for the host until the next conversion completes
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            timeout_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_BUSY_WAIT && state_d == ST_ACK) begin
                timeout_q <= 1'b1;
            end else if (state_q == ST_RD_HIGH && state_d == ST_ACK) begin
                timeout_q <= 1'b0;
            end
        end
    end

    // outputs decode the registered state
    assign conv_ack_o     = (state_q == ST_ACK);
    assign busy_timeout_o = timeout_q;
    assign rx_cnvst_o     = (state_q == ST_CNVST);
    assign rx_rd_n_o      = (state_q != ST_RD_LOW);

    // chip select spans both reads and the gap between them
    // and goes high together with the last rd_n rise
    assign rx_cs_n_o = !((state_q == ST_RD_LOW) ||
                         (state_q == ST_RD_HIGH && !cap_last_i));

    // ************************************************************
    // checks
    // ************************************************************

    // a new conversion must never start while a read is in progress
    cnvst_cs_excl_a: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        !(rx_cnvst_o && !rx_cs_n_o)
    );

    // four phase handshake, ack only answers a live request
    ack_req_a: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        $rose(conv_ack_o) |-> conv_req_i
    );

endmodule

// ==== source/adc_sample_capture.sv ====
// Channel sample capture
`timescale 1ns/1ps

module adc_sample_capture (
    input  logic                   sys_clk_i,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  logic                   strobe_i,
    input  adc_par_pkg::adc_word_t db_i,
    output adc_par_pkg::adc_word_t sample_a_o,
    output adc_par_pkg::adc_word_t sample_b_o,
    output logic                   last_o
);

    import adc_par_pkg::*;

    // which channel the next strobe belongs to
    rd_idx_t   rd_idx_q;
    adc_word_t sample_a_q;
    adc_word_t sample_b_q;

    // ************************************************************
    // read index
    // ************************************************************

    // start rewinds to channel A, each strobe moves to the next channel
    // and the index saturates once all reads are done
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            rd_idx_q <= '0;
        end else if (start_i) begin
            rd_idx_q <= '0;
        end else if (strobe_i && !last_o) begin
            rd_idx_q <= rd_idx_q + 1'b1;
        end
    end

    assign last_o = (rd_idx_q == rd_idx_t'(NUM_READS));

    // ************************************************************
    // sample registers
    // ************************************************************

    // the converter puts channel A out on the first read and channel B on
    // the second, a channel that is not read keeps its previous sample
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            sample_a_q <= '0;
            sample_b_q <= '0;
        end else if (strobe_i) begin
            if (rd_idx_q == rd_idx_t'(0)) begin
                sample_a_q <= db_i;
            end else if (rd_idx_q == rd_idx_t'(1)) begin
                sample_b_q <= db_i;
            end
        end
    end

    assign sample_a_o = sample_a_q;
    assign sample_b_o = sample_b_q;

    // ************************************************************
    // checks
    // ************************************************************

    // the FSM leaves the read loop as soon as last is seen
    // so an extra strobe means its read count and ours disagree
    no_extra_strobe_a: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        strobe_i |-> !last_o
    );

endmodule

// ==== source/adc_step_timer.sv ====
// Converter phase step timer
`timescale 1ns/1ps

module adc_step_timer (
    input  logic                  sys_clk_i,
    input  logic                  rst_n_i,
    input  logic                  load_i,
    input  adc_par_pkg::tmr_cnt_t load_val_i,
    output logic                  done_o
);

    import adc_par_pkg::*;

    // remaining cycles of the current phase
    tmr_cnt_t cnt_q;

    // ************************************************************
    // down counter
    // ************************************************************

    // a load always wins over counting so a new phase restarts cleanly
    // even if the previous count had not yet run out
    always_ff @(posedge sys_clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= load_val_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // the FSM loads on the same edge that moves it into a new phase
    // so the count is already nonzero on the first cycle of that phase
    // and done reads low there
    // done then comes back after load_val_i cycles and stays high while idle
    assign done_o = (cnt_q == '0);

    // ************************************************************
    // checks
    // ************************************************************

    // a zero load would leave done high and let the FSM skip a phase
    // without the timer ever having counted
    load_val_nonzero_a: assert property (
        @(posedge sys_clk_i) disable iff (!rst_n_i)
        load_i |-> (load_val_i != '0)
    );

endmodule

// ==== source/adc_par_pkg.sv ====
// AD7616 parallel controller package
package adc_par_pkg;

    // ************************************************************
    // converter timing, all values in sys_clk_i cycles
    // ************************************************************

    // width of the convert start pulse
    localparam int unsigned CNVST_CYCLES        = 4;
    // time the read strobe stays low for one channel
    localparam int unsigned RD_LOW_CYCLES       = 3;
    // gap with the read strobe high between two channel reads
    localparam int unsigned RD_HIGH_CYCLES      = 2;
    // longest wait for busy to fall before the conversion is abandoned
    localparam int unsigned BUSY_TIMEOUT_CYCLES = 200;
    // one read for channel A and one for channel B
    localparam int unsigned NUM_READS           = 2;

    // the read index has to be able to hold NUM_READS itself
    localparam int unsigned RD_IDX_W = $clog2(NUM_READS + 1);

    // ************************************************************
    // types
    // ************************************************************

    // one converter sample as it appears on the parallel data bus
    typedef logic [15:0] adc_word_t;

    // phase timer count, wide enough for the busy timeout
    typedef logic [7:0] tmr_cnt_t;

    // index of the next channel read within a conversion
    typedef logic [RD_IDX_W-1:0] rd_idx_t;

    // controller states, one per phase of the conversion
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CNVST,
        ST_BUSY_WAIT,
        ST_RD_LOW,
        ST_RD_HIGH,
        ST_ACK
    } ctrl_state_t;

endpackage
